//--- tb.f
rtl/sys_bus_pkg.sv
rtl/sys_io_pkg.sv
rtl/apb_decoder.sv
rtl/input_port_mux.sv
rtl/ms_timer.sv
rtl/pause_ctrl.sv
rtl/work_ram.sv
rtl/sys_top.sv
verif/sys_props.sv
verif/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f

output=$(./obj_dir/Vtb_top | tee /dev/stderr)

if echo "$output" | grep -qx "Test passed"; then
	exit 0
else
	exit 1
fi

//--- verif/tb_top.sv
`timescale 1ns/1ps

module tb_top;
	import sys_bus_pkg::*;
	import sys_io_pkg::*;

	logic clk_24;
	logic reset;
	logic pause;
	apb_req_t apb_req;
	ctrl_inputs_t ctrl_in;
	apb_rsp_t apb_rsp;

	// reference model of the work RAM
	logic [7:0] ram_model [0:16383];
	// rising edges since time zero
	longint cycle_count;
	int errors;
	int checks;
	// result of the last transfer
	logic [7:0] rd_byte;
	logic rd_err;
	logic rd_done;
	longint done_cycle;

	sys_top u_dut (
		.clk_24(clk_24),
		.reset(reset),
		.pause(pause),
		.apb_req(apb_req),
		.ctrl_in(ctrl_in),
		.apb_rsp(apb_rsp)
	);

	bind apb_decoder sys_props u_props (
		.clk_24(clk_24),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

	initial
		clk_24 = 1'b0;
	always #10 clk_24 = ~clk_24;

	always @(posedge clk_24)
		cycle_count <= cycle_count + 1;

	task automatic check_val(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		checks++;
		if (act !== exp)
		begin
			$display("** Error: %s: expected %0h, actual %0h", name, exp, act);
			errors++;
		end
	endtask

	// setup cycle, then access cycle held until released
	task automatic start_xfer(input logic wr, input logic [15:0] addr, input logic [7:0] data);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = wr;
		apb_req.paddr = addr;
		apb_req.pwdata = data;
		@(posedge clk_24);
		#1;
		apb_req.penable = 1'b1;
	endtask

	// pready sampled mid cycle, the next rising edge completes
	task automatic wait_ready(input int limit);
		int waited;
		waited = 0;
		rd_done = 1'b0;
		while (!rd_done && waited < limit)
		begin
			@(negedge clk_24);
			if (apb_rsp.pready)
			begin
				rd_done = 1'b1;
				rd_byte = apb_rsp.prdata;
				rd_err = apb_rsp.pslverr;
				done_cycle = cycle_count + 1;
			end
			waited++;
			@(posedge clk_24);
			#1;
		end
	endtask

	task automatic do_xfer(input logic wr, input logic [15:0] addr, input logic [7:0] data);
		start_xfer(wr, addr, data);
		wait_ready(50);
		if (!rd_done)
		begin
			$display("Error: transfer to %h got no pready within 50 cycles", addr);
			errors++;
		end
		apb_req = '0;
	endtask

	// one controller source, widened with zeros
	function automatic logic [191:0] source_bits(input int k);
		case (k)
			0: source_bits = ctrl_in.joystick;
			1: source_bits = {96'd0, ctrl_in.analog};
			2: source_bits = {144'd0, ctrl_in.paddle};
			3: source_bits = {181'd0, ctrl_in.ps2_key};
			default: source_bits = {159'd0, ctrl_in.timestamp};
		endcase
	endfunction

	// lsb-first byte, bits past the source width read 0
	function automatic logic [7:0] model_byte(input logic [191:0] src, input int width,
		input int idx);
		logic [7:0] val;
		val = '0;
		for (int b = 0; b < 8; b++)
			if (idx * 8 + b < width)
				val[b] = src[idx * 8 + b];
		return val;
	endfunction

	initial
	begin
		logic [7:0] pages [5];
		int widths [5];
		logic [383:0] ctrl_bits;
		logic [15:0] bad;
		logic [7:0] data;
		logic [7:0] lo;
		longint clear_cycle;
		longint elapsed;
		longint exp_ms;
		int a;
		int timer_val;
		pages = '{8'h81, 8'h82, 8'h84, 8'h86, 8'h88};
		widths = '{192, 96, 48, 11, 33};
		void'($urandom(57));
		errors = 0;
		checks = 0;
		cycle_count = 0;
		pause = 1'b0;
		apb_req = '0;
		ctrl_in = '0;
		reset = 1'b1;
		repeat (16) @(posedge clk_24);
		#1;
		reset = 1'b0;
		check_val("reset response", 16'h0, {6'd0, apb_rsp});

		// work RAM, full fill then random traffic
		for (int i = 0; i < 16384; i++)
		begin
			ram_model[i] = i[7:0] ^ {2'b10, i[13:8]};
			do_xfer(1'b1, 16'hC000 | i[13:0], ram_model[i]);
		end
		for (int i = 0; i < 600; i++)
		begin
			a = $urandom % 16384;
			data = $urandom;
			if ($urandom % 2)
			begin
				ram_model[a] = data;
				do_xfer(1'b1, 16'hC000 | a[13:0], data);
				check_val("ram write err", 16'h0, rd_err);
			end
			else
			begin
				do_xfer(1'b0, 16'hC000 | a[13:0], 8'h00);
				check_val("ram read", ram_model[a], rd_byte);
			end
		end

		// controller pages, every byte index
		for (int i = 0; i < 12; i++)
			ctrl_bits[i*32 +: 32] = $urandom;
		ctrl_in = ctrl_bits[379:0];
		for (int k = 0; k < 5; k++)
			for (int idx = 0; idx < 32; idx++)
			begin
				data = $urandom;
				do_xfer(1'b0, {pages[k], data[2:0], idx[4:0]}, 8'h00);
				check_val("port read",
					{1'b0, model_byte(source_bits(k), widths[k], idx)},
					{rd_err, rd_byte});
			end

		// error responses leave the RAM untouched
		for (int i = 0; i < 60; i++)
		begin
			data = $urandom;
			case (i % 3)
				0: bad = {pages[$urandom % 5], 8'($urandom)};
				1: bad = {1'b0, 15'($urandom)};
				default: bad = {8'h8B + 8'($urandom % 53), 8'($urandom)};
			endcase
			do_xfer(1'b1, bad, data);
			check_val("bad write", 16'h0100, {7'd0, rd_err, rd_byte});
			if (i % 3 != 0)
			begin
				do_xfer(1'b0, bad, 8'h00);
				check_val("unmapped read", 16'h0100, {7'd0, rd_err, rd_byte});
			end
			do_xfer(1'b0, 16'hC000 | bad[13:0], 8'h00);
			check_val("ram after bad write", ram_model[bad[13:0]], rd_byte);
		end

		// let the free running count move well away from zero
		repeat (60000) @(posedge clk_24);
		#1;
		// millisecond timer against elapsed cycles
		do_xfer(1'b1, {PAGE_TIMER, 8'($urandom)}, 8'($urandom));
		check_val("timer write err", 16'h0, rd_err);
		clear_cycle = done_cycle;
		for (int k = 0; k < 2; k++)
		begin
			repeat (60000) @(posedge clk_24);
			#1;
			do_xfer(1'b0, {PAGE_TIMER, 8'h00}, 8'h00);
			lo = rd_byte;
			elapsed = done_cycle - clear_cycle;
			do_xfer(1'b0, {PAGE_TIMER, 8'h01}, 8'h00);
			timer_val = {rd_byte, lo};
			exp_ms = elapsed / MS_PRESCALE;
			checks++;
			if (timer_val > exp_ms + 1 || timer_val + 1 < exp_ms)
			begin
				$display("** Error: timer read: expected %0d, actual %0d", exp_ms, timer_val);
				errors++;
			end
		end

		// self pause holds the next transfer until pause pulses
		do_xfer(1'b0, {PAUSE_PREFIX, 4'($urandom)}, 8'h00);
		check_val("pause page read", 16'h0, {7'd0, rd_err, rd_byte});
		do_xfer(1'b1, {PAUSE_PREFIX, 4'($urandom)}, 8'($urandom));
		check_val("pause page write err", 16'h0, rd_err);
		a = $urandom % 16384;
		start_xfer(1'b0, 16'hC000 | a[13:0], 8'h00);
		wait_ready(200);
		checks++;
		if (rd_done)
		begin
			$display("Error: transfer completed while the self pause was set");
			errors++;
		end
		pause = 1'b1;
		repeat (3) @(posedge clk_24);
		#1;
		pause = 1'b0;
		wait_ready(20);
		if (!rd_done)
		begin
			$display("Error: transfer still stalled after the pause pulse");
			errors++;
		end
		else
			check_val("read after pause", ram_model[a], rd_byte);
		apb_req = '0;

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- verif/sys_props.sv
`timescale 1ns/1ps

module sys_props (
	input logic clk_24,
	input logic reset,
	input sys_bus_pkg::apb_req_t apb_req,
	input sys_bus_pkg::apb_rsp_t apb_rsp
);

	// error response only on a completing cycle
	err_with_ready: assert property (@(posedge clk_24) disable iff (reset)
		apb_rsp.pslverr |-> apb_rsp.pready)
		else $error("pslverr seen while pready is low");

	// requester holds the access cycle until pready
	req_stable: assert property (@(posedge clk_24) disable iff (reset)
		(apb_req.psel && apb_req.penable && !apb_rsp.pready) |=>
		(apb_req.psel && apb_req.penable && $stable(apb_req.pwrite)
		&& $stable(apb_req.paddr) && $stable(apb_req.pwdata)))
		else $error("request changed during a wait state");

	// ready only in an access cycle
	ready_in_access: assert property (@(posedge clk_24) disable iff (reset)
		apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
		else $error("pready raised outside an access cycle");

endmodule

//--- rtl/sys_top.sv
`timescale 1ns/1ps

module sys_top (
	input logic clk_24,
	input logic reset,
	input logic pause,
	input sys_bus_pkg::apb_req_t apb_req,
	input sys_io_pkg::ctrl_inputs_t ctrl_in,
	output sys_bus_pkg::apb_rsp_t apb_rsp
);
	import sys_bus_pkg::*;
	import sys_io_pkg::*;

	region_t region;
	logic [BYTE_W-1:0] port_byte;
	logic [TIMER_W-1:0] timer_count;
	logic [BYTE_W-1:0] ram_rdata;
	logic timer_clear;
	logic pause_set;
	logic pause_system;
	logic ram_we;

	// host bus target, decode and response
	apb_decoder u_decoder (
		.clk_24(clk_24),
		.reset(reset),
		.apb_req(apb_req),
		.pause_system(pause_system),
		.port_byte(port_byte),
		.timer_count(timer_count),
		.ram_rdata(ram_rdata),
		.apb_rsp(apb_rsp),
		.region(region),
		.timer_clear(timer_clear),
		.pause_set(pause_set),
		.ram_we(ram_we)
	);

	// controller readback, low addr bits pick the byte
	input_port_mux u_ports (
		.region(region),
		.byte_index(apb_req.paddr[4:0]),
		.ctrl_in(ctrl_in),
		.port_byte(port_byte)
	);

	// millisecond timer
	ms_timer u_timer (
		.clk_24(clk_24),
		.reset(reset),
		.clear(timer_clear),
		.count(timer_count)
	);

	// self pause trigger
	pause_ctrl u_pause (
		.clk_24(clk_24),
		.reset(reset),
		.pause(pause),
		.pause_set(pause_set),
		.pause_system(pause_system)
	);

	// work RAM straight off the request
	work_ram u_wkram (
		.clk_24(clk_24),
		.addr(apb_req.paddr[WKRAM_AW-1:0]),
		.we(ram_we),
		.wdata(apb_req.pwdata),
		.rdata(ram_rdata)
	);

endmodule

//--- rtl/work_ram.sv
`timescale 1ns/1ps

module work_ram (
	input logic clk_24,
	input logic [sys_bus_pkg::WKRAM_AW-1:0] addr,
	input logic we,
	input logic [sys_bus_pkg::BYTE_W-1:0] wdata,
	output logic [sys_bus_pkg::BYTE_W-1:0] rdata
);
	import sys_bus_pkg::*;

	// 0xC000 to 0xFFFF, 16384 bytes
	logic [BYTE_W-1:0] mem [0:(2**WKRAM_AW)-1];

	always_ff @(posedge clk_24)
	begin
		if (we)
		begin
			mem[addr] <= wdata;
			// new data shows on the read port at once
			rdata <= wdata;
		end
		else
		begin
			// address sampled every clock
			rdata <= mem[addr];
		end
	end

endmodule

//--- rtl/pause_ctrl.sv
`timescale 1ns/1ps

module pause_ctrl (
	input logic clk_24,
	input logic reset,
	input logic pause,
	input logic pause_set,
	output logic pause_system
);

	// set by the host, released by the external pause
	logic pause_trigger;

	always_ff @(posedge clk_24)
	begin
		if (reset)
			pause_trigger <= 1'b0;
		// external pause wins over a new request
		else if (pause)
			pause_trigger <= 1'b0;
		else if (pause_set)
			pause_trigger <= 1'b1;
	end

	// either source stalls the bus
	assign pause_system = pause_trigger || pause;

endmodule

//--- rtl/ms_timer.sv
`timescale 1ns/1ps

module ms_timer (
	input logic clk_24,
	input logic reset,
	input logic clear,
	output logic [sys_io_pkg::TIMER_W-1:0] count
);
	import sys_io_pkg::*;

	// last prescaler value before a tick
	localparam logic [14:0] PRESCALE_TOP = MS_PRESCALE - 15'd1;

	logic [14:0] prescale;
	logic tick;

	// one pulse per millisecond at 24 MHz
	assign tick = (prescale == PRESCALE_TOP);

	always_ff @(posedge clk_24)
	begin
		// host write to the timer page restarts from zero
		if (reset || clear)
		begin
			prescale <= '0;
			count <= '0;
		end
		else if (tick)
		begin
			prescale <= '0;
			// wraps after about 65 seconds
			count <= count + 1'b1;
		end
		else
		begin
			prescale <= prescale + 15'd1;
		end
	end

endmodule

//--- rtl/input_port_mux.sv
`timescale 1ns/1ps

module input_port_mux (
	input sys_bus_pkg::region_t region,
	input logic [4:0] byte_index,
	input sys_io_pkg::ctrl_inputs_t ctrl_in,
	output logic [sys_bus_pkg::BYTE_W-1:0] port_byte
);
	import sys_bus_pkg::*;
	import sys_io_pkg::*;

	logic [BYTE_W-1:0] joy_byte;
	logic [BYTE_W-1:0] analog_byte;
	logic [BYTE_W-1:0] paddle_byte;
	logic [BYTE_W-1:0] ps2_byte;
	logic [BYTE_W-1:0] ts_byte;

	// byte idx of a source, lsb first, zero past its length
	function automatic logic [BYTE_W-1:0] pick_byte(
		input logic [191:0] src,
		input logic [4:0] idx,
		input logic [4:0] count
	);
		logic [191:0] shifted;
		shifted = src >> {idx, 3'b000};
		if (idx < count)
			pick_byte = shifted[BYTE_W-1:0];
		else
			pick_byte = '0;
	endfunction

	// narrower sources widened with zeros
	assign joy_byte = pick_byte(ctrl_in.joystick, byte_index, JOY_BYTES);
	assign analog_byte = pick_byte(192'(ctrl_in.analog), byte_index, ANALOG_BYTES);
	assign paddle_byte = pick_byte(192'(ctrl_in.paddle), byte_index, PADDLE_BYTES);
	// upper ps2 byte holds only 3 flag bits
	assign ps2_byte = pick_byte(192'(ctrl_in.ps2_key), byte_index, PS2_BYTES);
	// top timestamp byte carries just the toggle
	assign ts_byte = pick_byte(192'(ctrl_in.timestamp), byte_index, TS_BYTES);

	// source select by page
	always_comb
	begin
		case (region)
			REG_JOYSTICK:
				port_byte = joy_byte;
			REG_ANALOG:
				port_byte = analog_byte;
			REG_PADDLE:
				port_byte = paddle_byte;
			REG_PS2_KEY:
				port_byte = ps2_byte;
			REG_TIMESTAMP:
				port_byte = ts_byte;
			// timer, pause, ram and unmapped
			default:
				port_byte = '0;
		endcase
	end

endmodule

//--- rtl/apb_decoder.sv
`timescale 1ns/1ps

module apb_decoder (
	input logic clk_24,
	input logic reset,
	input sys_bus_pkg::apb_req_t apb_req,
	input logic pause_system,
	input logic [7:0] port_byte,
	input logic [15:0] timer_count,
	input logic [7:0] ram_rdata,
	output sys_bus_pkg::apb_rsp_t apb_rsp,
	output sys_bus_pkg::region_t region,
	output logic timer_clear,
	output logic pause_set,
	output logic ram_we
);
	import sys_bus_pkg::*;

	logic ready;
	logic xfer_done;
	logic rd_only;
	logic acc_err;
	logic wr_ok;
	logic [BYTE_W-1:0] rd_mux;
	// registered response state
	logic pready_q;
	logic pslverr_q;
	logic rd_ram_q;
	logic [BYTE_W-1:0] prdata_q;

	// page and prefix decode
	always_comb
	begin
		region = REG_NONE;
		if (apb_req.paddr[15:14] == WKRAM_PREFIX)
			region = REG_WKRAM;
		else if (apb_req.paddr[15:4] == PAUSE_PREFIX)
			region = REG_PAUSE;
		else
		begin
			case (apb_req.paddr[15:8])
				PAGE_JOYSTICK: region = REG_JOYSTICK;
				PAGE_ANALOG: region = REG_ANALOG;
				PAGE_PADDLE: region = REG_PADDLE;
				PAGE_PS2_KEY: region = REG_PS2_KEY;
				PAGE_TIMESTAMP: region = REG_TIMESTAMP;
				PAGE_TIMER: region = REG_TIMER;
				default: region = REG_NONE;
			endcase
		end
	end

	// controller pages cannot be written
	assign rd_only = region inside {REG_JOYSTICK, REG_ANALOG, REG_PADDLE, REG_PS2_KEY,
		REG_TIMESTAMP};
	// unmapped space errors on any access
	assign acc_err = (region == REG_NONE) || (apb_req.pwrite && rd_only);

	// read data for everything except work RAM
	always_comb
	begin
		case (region)
			REG_JOYSTICK, REG_ANALOG, REG_PADDLE, REG_PS2_KEY, REG_TIMESTAMP:
				rd_mux = port_byte;
			// addr bit 0 picks the timer byte
			REG_TIMER:
				rd_mux = apb_req.paddr[0] ? timer_count[15:8] : timer_count[7:0];
			default:
				rd_mux = '0;
		endcase
	end

	// any pause source holds the bus
	assign ready = pready_q && !pause_system;
	assign xfer_done = apb_req.psel && apb_req.penable && ready;

	// strobes fire on the completing edge only
	assign wr_ok = xfer_done && apb_req.pwrite && !acc_err;
	assign timer_clear = wr_ok && (region == REG_TIMER);
	assign pause_set = wr_ok && (region == REG_PAUSE);
	assign ram_we = wr_ok && (region == REG_WKRAM);

	always_ff @(posedge clk_24)
	begin
		if (reset || xfer_done)
		begin
			pready_q <= 1'b0;
			pslverr_q <= 1'b0;
			rd_ram_q <= 1'b0;
			prdata_q <= '0;
		end
		else if (apb_req.psel && !pause_system)
		begin
			// setup or stalled access, answer next cycle
			pready_q <= 1'b1;
			pslverr_q <= acc_err;
			rd_ram_q <= !apb_req.pwrite && (region == REG_WKRAM);
			prdata_q <= (acc_err || apb_req.pwrite) ? '0 : rd_mux;
		end
		else
		begin
			pready_q <= 1'b0;
			pslverr_q <= 1'b0;
			rd_ram_q <= 1'b0;
			prdata_q <= '0;
		end
	end

	// ram data arrives a cycle after its address
	assign apb_rsp.prdata = rd_ram_q ? ram_rdata : prdata_q;
	assign apb_rsp.pready = ready;
	assign apb_rsp.pslverr = pslverr_q && !pause_system;

endmodule

//--- rtl/sys_io_pkg.sv
package sys_io_pkg;

	// bytes readable from each controller source
	// 6 devices, 32 buttons each
	localparam logic [4:0] JOY_BYTES = 5'd24;
	// 6 devices, Y in the high byte, X in the low byte
	localparam logic [4:0] ANALOG_BYTES = 5'd12;
	// 6 devices, one byte each
	localparam logic [4:0] PADDLE_BYTES = 5'd6;
	// key code plus extended, pressed and toggle bits
	localparam logic [4:0] PS2_BYTES = 5'd2;
	// seconds count plus change toggle
	localparam logic [4:0] TS_BYTES = 5'd5;

	// 24 MHz clocks per millisecond
	localparam logic [14:0] MS_PRESCALE = 15'd24000;

	// millisecond count width
	localparam int TIMER_W = 16;

	// everything the host can sample from the controllers
	typedef struct packed {
		// joystick buttons, device 0 in the low bits
		logic [191:0] joystick;
		// left analog sticks
		logic [95:0] analog;
		// paddle positions 0..255
		logic [47:0] paddle;
		// [8] extended, [9] pressed, [10] toggles per event
		logic [10:0] ps2_key;
		// [31:0] seconds, [32] toggles per change
		logic [32:0] timestamp;
	} ctrl_inputs_t;

endpackage

//--- rtl/sys_bus_pkg.sv
package sys_bus_pkg;

	// data path width of the system bus
	localparam int BYTE_W = 8;

	// work RAM address width, 16 KiB
	localparam int WKRAM_AW = 14;

	// memory mapped input pages, upper address byte
	localparam logic [7:0] PAGE_JOYSTICK = 8'h81;
	localparam logic [7:0] PAGE_ANALOG = 8'h82;
	// paddle page, 0x84
	localparam logic [7:0] PAGE_PADDLE = 8'h84;
	localparam logic [7:0] PAGE_PS2_KEY = 8'h86;
	localparam logic [7:0] PAGE_TIMESTAMP = 8'h88;
	localparam logic [7:0] PAGE_TIMER = 8'h89;

	// pause trigger, 0x8A30 to 0x8A3F
	localparam logic [11:0] PAUSE_PREFIX = 12'h8A3;

	// work RAM, 0xC000 to 0xFFFF
	localparam logic [1:0] WKRAM_PREFIX = 2'd3;

	// apb request from the host side
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [15:0] paddr;
		logic [BYTE_W-1:0] pwdata;
	} apb_req_t;

	// apb response back to the host
	typedef struct packed {
		logic [BYTE_W-1:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// decoded address regions
	typedef enum logic [3:0] {
		REG_NONE,
		REG_JOYSTICK,
		REG_ANALOG,
		REG_PADDLE,
		REG_PS2_KEY,
		REG_TIMESTAMP,
		REG_TIMER,
		REG_PAUSE,
		REG_WKRAM
	} region_t;

endpackage
